/* sources.f */
src/fixed_point_pkg.sv
src/cnn_ctrl_pkg.sv
src/image_fetch.sv
src/conv_mac.sv
src/pool_reader.sv
src/layer_sequencer.sv
src/cnn_conv_top.sv
tb/cnn_mem_model.sv
tb/cnn_tb.sv

/* tb/cnn_tb.sv */
`timescale 1ns/100ps

module cnn_tb
    import fixed_point_pkg::*;
    import cnn_ctrl_pkg::*;
();

    localparam int IMG_W = 64;
    localparam int HALF_W = IMG_W / 2;
    localparam int ADDR_W = $clog2(IMG_W * IMG_W);
    localparam int N0 = IMG_W * IMG_W;
    localparam int N1 = HALF_W * HALF_W;
    // Two convolution passes plus two pooling passes, with some slack.
    localparam int FRAME_CYCLES = 2 * (IMG_W + 2) * (IMG_W + 2) + 2 * 5 * N1 + 100;
    localparam int CYCLE_LIMIT = 3 * 2 * FRAME_CYCLES;

    logic clk;
    logic reset;
    logic ready;
    logic clear_counts;
    pixel_t idata;
    pixel_t cdata_rd;
    logic busy;
    logic [ADDR_W-1:0] iaddr;
    logic cwr;
    logic [ADDR_W-1:0] caddr_wr;
    pixel_t cdata_wr;
    logic crd;
    logic [ADDR_W-1:0] caddr_rd;
    mem_sel_t csel;

    integer seed;
    int mismatch_count;
    int failure_count;
    int cycle_count;

    pixel_t img [0:N0-1];
    pixel_t exp0 [0:N0-1];
    pixel_t exp1 [0:N0-1];
    pixel_t pool0 [0:N1-1];
    pixel_t pool1 [0:N1-1];

    cnn_conv_top #(
        .IMG_W(IMG_W)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .ready(ready),
        .idata(idata),
        .cdata_rd(cdata_rd),
        .busy(busy),
        .iaddr(iaddr),
        .cwr(cwr),
        .caddr_wr(caddr_wr),
        .cdata_wr(cdata_wr),
        .crd(crd),
        .caddr_rd(caddr_rd),
        .csel(csel)
    );

    cnn_mem_model #(
        .IMG_W(IMG_W)
    ) u_mem (
        .clk(clk),
        .clear_counts(clear_counts),
        .iaddr(iaddr),
        .idata(idata),
        .crd(crd),
        .caddr_rd(caddr_rd),
        .cdata_rd(cdata_rd),
        .cwr(cwr),
        .caddr_wr(caddr_wr),
        .cdata_wr(cdata_wr),
        .csel(csel)
    );

    always #4 clk = ~clk;

    task automatic check_equal(input string name, input logic [PIXEL_W-1:0] actual,
                               input logic [PIXEL_W-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s actual %h expected %h", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        failure_count++;
    endtask

    // Zero padding, rounding on bit 15, bias, then ReLU.
    function automatic pixel_t conv_ref(input int r, input int c, input bit k);
        longint sum;
        logic [63:0] bits;
        logic [PIXEL_W-1:0] t;
        pixel_t p;
        pixel_t w;
        int rr;
        int cc;
        sum = 0;
        for (int kr = 0; kr < 3; kr++) begin
            for (int kc = 0; kc < 3; kc++) begin
                rr = r + kr - 1;
                cc = c + kc - 1;
                if (rr < 0 || rr >= IMG_W || cc < 0 || cc >= IMG_W)
                    p = '0;
                else
                    p = img[rr*IMG_W + cc];
                w = k ? KERNEL1[3*kr + kc] : KERNEL0[3*kr + kc];
                sum += longint'(p) * longint'(w);
            end
        end
        bits = sum;
        t = bits[35:16] + bits[15];
        t = t + (k ? BIAS1 : BIAS0);
        return t[PIXEL_W-1] ? pixel_t'(0) : pixel_t'(t);
    endfunction

    function automatic pixel_t block_max(input pixel_t a, input pixel_t b,
                                         input pixel_t c, input pixel_t d);
        pixel_t m;
        m = a;
        if (b > m) m = b;
        if (c > m) m = c;
        if (d > m) m = d;
        return m;
    endfunction

    task automatic load_image();
        logic [31:0] rnd;
        for (int a = 0; a < N0; a++) begin
            rnd = $random(seed);
            img[a] = {rnd[18], rnd[18:0]};   // Within +-4.0.
            u_mem.image[a] = img[a];
        end
    endtask

    task automatic build_model();
        int a;
        for (int r = 0; r < IMG_W; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                exp0[r*IMG_W + c] = conv_ref(r, c, 1'b0);
                exp1[r*IMG_W + c] = conv_ref(r, c, 1'b1);
            end
        end
        for (int br = 0; br < HALF_W; br++) begin
            for (int bc = 0; bc < HALF_W; bc++) begin
                a = 2*br*IMG_W + 2*bc;
                pool0[br*HALF_W + bc] = block_max(exp0[a], exp0[a+1],
                                                  exp0[a+IMG_W], exp0[a+IMG_W+1]);
                pool1[br*HALF_W + bc] = block_max(exp1[a], exp1[a+1],
                                                  exp1[a+IMG_W], exp1[a+IMG_W+1]);
            end
        end
    endtask

    task automatic check_count(input string map, input int addr, input int count);
        if (count > 1)
            report_failure($sformatf("%s memory written twice at one address (%0d)", map, addr));
        else if (count == 0)
            report_failure($sformatf("%s memory never written at address %0d", map, addr));
    endtask

    task automatic check_frame(input int frame);
        for (int a = 0; a < N0; a++) begin
            check_equal($sformatf("frame %0d l0_k0[%0d]", frame, a), u_mem.l0_k0[a], exp0[a]);
            check_equal($sformatf("frame %0d l0_k1[%0d]", frame, a), u_mem.l0_k1[a], exp1[a]);
            check_count("layer-0 kernel-0", a, u_mem.cnt_l0_k0[a]);
            check_count("layer-0 kernel-1", a, u_mem.cnt_l0_k1[a]);
        end
        for (int a = 0; a < N1; a++) begin
            check_equal($sformatf("frame %0d l1_k0[%0d]", frame, a), u_mem.l1_k0[a], pool0[a]);
            check_equal($sformatf("frame %0d l1_k1[%0d]", frame, a), u_mem.l1_k1[a], pool1[a]);
            check_count("layer-1 kernel-0", a, u_mem.cnt_l1_k0[a]);
            check_count("layer-1 kernel-1", a, u_mem.cnt_l1_k1[a]);
        end
        if (u_mem.stray_writes != 0)
            report_failure("write with csel naming no memory");
    endtask

    task automatic run_frame(input int frame);
        int waited;
        load_image();
        build_model();
        @(negedge clk);
        clear_counts = 1'b1;
        @(negedge clk);
        clear_counts = 1'b0;
        ready = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!busy && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!busy)
            report_failure("busy did not rise after ready");
        ready = 1'b0;
        while (busy)
            @(negedge clk);
        repeat (10) @(negedge clk);   // Catch late writes.
        check_frame(frame);
        $display("Frame %0d checked at %0t ns", frame, $time);
    endtask

    // No write may land outside a busy period.
    always @(negedge clk) begin
        if (!reset && cwr && !busy)
            report_failure("memory write while busy is low");
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: busy never fell, run stopped after %0d cycles", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        ready = 1'b0;
        clear_counts = 1'b1;
        seed = 23;
        mismatch_count = 0;
        failure_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        clear_counts = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_equal("busy", busy, 0);
            check_equal("cwr", cwr, 0);
            check_equal("crd", crd, 0);
            check_equal("csel", csel, MEM_NONE);
        end

        run_frame(1);
        run_frame(2);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb/cnn_mem_model.sv */
`timescale 1ns/100ps

module cnn_mem_model
    import fixed_point_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter int IMG_W = 64,
    localparam int ADDR_W = $clog2(IMG_W * IMG_W),
    localparam int N0 = IMG_W * IMG_W,
    localparam int N1 = N0 / 4
) (
    input  logic              clk,
    input  logic              clear_counts,
    input  logic [ADDR_W-1:0] iaddr,
    output pixel_t            idata,
    input  logic              crd,
    input  logic [ADDR_W-1:0] caddr_rd,
    output pixel_t            cdata_rd,
    input  logic              cwr,
    input  logic [ADDR_W-1:0] caddr_wr,
    input  pixel_t            cdata_wr,
    input  mem_sel_t          csel
);

    pixel_t image [0:N0-1];   // Loaded by the testbench.
    pixel_t l0_k0 [0:N0-1];
    pixel_t l0_k1 [0:N0-1];
    pixel_t l1_k0 [0:N1-1];
    pixel_t l1_k1 [0:N1-1];

    // Write counts per address.
    int cnt_l0_k0 [0:N0-1];
    int cnt_l0_k1 [0:N0-1];
    int cnt_l1_k0 [0:N1-1];
    int cnt_l1_k1 [0:N1-1];
    int stray_writes;   // Writes with csel naming no memory.

    assign idata = image[iaddr];

    always_comb begin
        case (csel)
            MEM_L0_K0: cdata_rd = crd ? l0_k0[caddr_rd] : pixel_t'(0);
            MEM_L0_K1: cdata_rd = crd ? l0_k1[caddr_rd] : pixel_t'(0);
            default:   cdata_rd = '0;
        endcase
    end

    always @(posedge clk) begin
        if (clear_counts) begin
            for (int i = 0; i < N0; i++) begin
                cnt_l0_k0[i] <= 0;
                cnt_l0_k1[i] <= 0;
            end
            for (int i = 0; i < N1; i++) begin
                cnt_l1_k0[i] <= 0;
                cnt_l1_k1[i] <= 0;
            end
            stray_writes <= 0;
        end else if (cwr) begin
            case (csel)
                MEM_L0_K0: begin
                    l0_k0[caddr_wr] <= cdata_wr;
                    cnt_l0_k0[caddr_wr] <= cnt_l0_k0[caddr_wr] + 1;
                end
                MEM_L0_K1: begin
                    l0_k1[caddr_wr] <= cdata_wr;
                    cnt_l0_k1[caddr_wr] <= cnt_l0_k1[caddr_wr] + 1;
                end
                MEM_L1_K0: begin
                    l1_k0[caddr_wr] <= cdata_wr;
                    cnt_l1_k0[caddr_wr] <= cnt_l1_k0[caddr_wr] + 1;
                end
                MEM_L1_K1: begin
                    l1_k1[caddr_wr] <= cdata_wr;
                    cnt_l1_k1[caddr_wr] <= cnt_l1_k1[caddr_wr] + 1;
                end
                default: stray_writes <= stray_writes + 1;
            endcase
        end
    end

endmodule

/* src/cnn_conv_top.sv */
`timescale 1ns/100ps

module cnn_conv_top
    import fixed_point_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter int IMG_W = 64,
    localparam int ADDR_W = $clog2(IMG_W * IMG_W)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ready,
    input  pixel_t            idata,
    input  pixel_t            cdata_rd,
    output logic              busy,
    output logic [ADDR_W-1:0] iaddr,
    output logic              cwr,
    output logic [ADDR_W-1:0] caddr_wr,
    output pixel_t            cdata_wr,
    output logic              crd,
    output logic [ADDR_W-1:0] caddr_rd,
    output mem_sel_t          csel
);

    logic fetch_start;
    logic fetch_done;
    logic win_valid;
    pixel_t window [0:8];
    logic [ADDR_W-1:0] win_index;
    logic kernel_sel;
    logic res_valid;
    pixel_t res_data;
    logic [ADDR_W-1:0] res_index;
    logic pool_start;
    logic pool_done;
    logic pool_valid;
    pixel_t pool_data;
    logic [ADDR_W-1:0] pool_index;

    image_fetch #(
        .IMG_W(IMG_W)
    ) u_image_fetch (
        .clk(clk),
        .reset(reset),
        .fetch_start(fetch_start),
        .idata(idata),
        .iaddr(iaddr),
        .win_valid(win_valid),
        .window(window),
        .win_index(win_index),
        .done(fetch_done)
    );

    conv_mac #(
        .ADDR_W(ADDR_W)
    ) u_conv_mac (
        .clk(clk),
        .reset(reset),
        .win_valid(win_valid),
        .window(window),
        .win_index(win_index),
        .kernel_sel(kernel_sel),
        .res_valid(res_valid),
        .res_data(res_data),
        .res_index(res_index)
    );

    pool_reader #(
        .IMG_W(IMG_W)
    ) u_pool_reader (
        .clk(clk),
        .reset(reset),
        .pool_start(pool_start),
        .cdata_rd(cdata_rd),
        .crd(crd),
        .caddr_rd(caddr_rd),
        .pool_valid(pool_valid),
        .pool_data(pool_data),
        .pool_index(pool_index),
        .done(pool_done)
    );

    layer_sequencer #(
        .ADDR_W(ADDR_W)
    ) u_layer_sequencer (
        .clk(clk),
        .reset(reset),
        .ready(ready),
        .fetch_done(fetch_done),
        .res_valid(res_valid),
        .res_data(res_data),
        .res_index(res_index),
        .pool_done(pool_done),
        .pool_valid(pool_valid),
        .pool_data(pool_data),
        .pool_index(pool_index),
        .busy(busy),
        .csel(csel),
        .kernel_sel(kernel_sel),
        .fetch_start(fetch_start),
        .pool_start(pool_start),
        .cwr(cwr),
        .caddr_wr(caddr_wr),
        .cdata_wr(cdata_wr)
    );

endmodule

/* src/layer_sequencer.sv */
`timescale 1ns/100ps

module layer_sequencer
    import fixed_point_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ready,
    input  logic              fetch_done,
    input  logic              res_valid,
    input  pixel_t            res_data,
    input  logic [ADDR_W-1:0] res_index,
    input  logic              pool_done,
    input  logic              pool_valid,
    input  pixel_t            pool_data,
    input  logic [ADDR_W-1:0] pool_index,
    output logic              busy,
    output mem_sel_t          csel,
    output logic              kernel_sel,
    output logic              fetch_start,
    output logic              pool_start,
    output logic              cwr,
    output logic [ADDR_W-1:0] caddr_wr,
    output pixel_t            cdata_wr
);

    layer_state_t state;
    layer_state_t state_next;
    logic in_conv;
    logic in_pool;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (ready) state_next = CONV_K0;
            CONV_K0: if (fetch_done) state_next = CONV_K1;
            CONV_K1: if (fetch_done) state_next = POOL_K0;
            POOL_K0: if (pool_done) state_next = POOL_K1;
            POOL_K1: if (pool_done) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            busy <= 1'b0;
            fetch_start <= 1'b0;
            pool_start <= 1'b0;
        end else begin
            state <= state_next;
            busy <= (state_next != IDLE);
            // One-cycle kick on entry to each worker state.
            fetch_start <= (state_next != state) &&
                           (state_next == CONV_K0 || state_next == CONV_K1);
            pool_start <= (state_next != state) &&
                          (state_next == POOL_K0 || state_next == POOL_K1);
        end
    end

    assign in_conv = (state == CONV_K0) || (state == CONV_K1);
    assign in_pool = (state == POOL_K0) || (state == POOL_K1);
    assign kernel_sel = (state == CONV_K1) || (state == POOL_K1);

    // While pooling, csel names the source map except in the write cycle.
    always_comb begin
        case (state)
            CONV_K0: csel = MEM_L0_K0;
            CONV_K1: csel = MEM_L0_K1;
            POOL_K0: csel = pool_valid ? MEM_L1_K0 : MEM_L0_K0;
            POOL_K1: csel = pool_valid ? MEM_L1_K1 : MEM_L0_K1;
            default: csel = MEM_NONE;
        endcase
    end

    always_comb begin
        if (in_pool) begin
            cwr = pool_valid;
            caddr_wr = pool_index;
            cdata_wr = pool_data;
        end else begin
            cwr = in_conv && res_valid;
            caddr_wr = res_index;
            cdata_wr = res_data;
        end
    end

endmodule

/* src/pool_reader.sv */
`timescale 1ns/100ps

module pool_reader
    import fixed_point_pkg::*;
#(
    parameter int IMG_W = 64,
    localparam int ADDR_W = $clog2(IMG_W * IMG_W)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pool_start,
    input  pixel_t            cdata_rd,
    output logic              crd,
    output logic [ADDR_W-1:0] caddr_rd,
    output logic              pool_valid,
    output pixel_t            pool_data,
    output logic [ADDR_W-1:0] pool_index,
    output logic              done
);

    localparam int HALF_W = IMG_W / 2;
    localparam int BLK_W = (HALF_W > 1) ? $clog2(HALF_W) : 1;

    logic running;
    logic [2:0] phase;   // 0..3 reads, 4 output.
    logic [BLK_W-1:0] brow;
    logic [BLK_W-1:0] bcol;
    logic last_blk;
    pixel_t max_q;
    pixel_t max_next;

    assign last_blk = (brow == BLK_W'(HALF_W - 1)) && (bcol == BLK_W'(HALF_W - 1));
    assign crd = running && (phase != 3'd4);

    // Read order TL, TR, BL, BR.
    assign caddr_rd = ADDR_W'((2*brow + phase[1]) * IMG_W + 2*bcol + phase[0]);

    // First read seeds the maximum.
    assign max_next = ((phase == 3'd0) || (cdata_rd > max_q)) ? cdata_rd : max_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            phase <= 3'd0;
            brow <= '0;
            bcol <= '0;
            pool_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            pool_valid <= running && (phase == 3'd3);
            done <= running && (phase == 3'd3) && last_blk;   // Same cycle as last write.
            if (pool_start) begin
                running <= 1'b1;
                phase <= 3'd0;
                brow <= '0;
                bcol <= '0;
            end else if (running) begin
                if (phase == 3'd4) begin
                    phase <= 3'd0;
                    if (last_blk) begin
                        running <= 1'b0;
                    end else if (bcol == BLK_W'(HALF_W - 1)) begin
                        bcol <= '0;
                        brow <= brow + 1'b1;
                    end else begin
                        bcol <= bcol + 1'b1;
                    end
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            max_q <= max_next;
            if (phase == 3'd3) begin
                pool_data <= max_next;
                pool_index <= ADDR_W'(brow * HALF_W + bcol);
            end
        end
    end

endmodule

/* src/conv_mac.sv */
`timescale 1ns/100ps

module conv_mac
    import fixed_point_pkg::*;
#(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              win_valid,
    input  pixel_t            window [0:8],
    input  logic [ADDR_W-1:0] win_index,
    input  logic              kernel_sel,
    output logic              res_valid,
    output pixel_t            res_data,
    output logic [ADDR_W-1:0] res_index
);

    acc_t sum;
    pixel_t rounded;
    pixel_t biased;
    pixel_t relu;

    always_comb begin
        acc_t prod;
        pixel_t weight;
        sum = '0;
        for (int i = 0; i < 9; i++) begin
            weight = kernel_sel ? KERNEL1[i] : KERNEL0[i];
            prod = acc_t'(window[i]) * acc_t'(weight);
            sum = sum + prod;
        end
    end

    // Back to Q4.16, round half up.
    always_comb begin
        rounded = sum[KEEP_MSB:FRAC_BITS] + sum[ROUND_BIT];
        biased = rounded + (kernel_sel ? BIAS1 : BIAS0);
        relu = biased[PIXEL_W-1] ? pixel_t'(0) : biased;
    end

    always_ff @(posedge clk) begin
        if (reset)
            res_valid <= 1'b0;
        else
            res_valid <= win_valid;
    end

    always_ff @(posedge clk) begin
        res_data <= relu;
        res_index <= win_index;
    end

endmodule

/* src/image_fetch.sv */
`timescale 1ns/100ps

module image_fetch
    import fixed_point_pkg::*;
#(
    parameter int IMG_W = 64,
    localparam int ADDR_W = $clog2(IMG_W * IMG_W)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_start,
    input  pixel_t            idata,
    output logic [ADDR_W-1:0] iaddr,
    output logic              win_valid,
    output pixel_t            window [0:8],
    output logic [ADDR_W-1:0] win_index,
    output logic              done
);

    localparam int PAD_W = IMG_W + 2;
    localparam int CNT_W = $clog2(PAD_W);
    localparam int LB_LEN = 2 * PAD_W + 3;

    logic running;
    logic [CNT_W-1:0] row;
    logic [CNT_W-1:0] col;
    logic at_pad;
    logic at_last;
    logic last_q;
    pixel_t line_buf [0:LB_LEN-1];

    assign at_pad = (row == 0) || (row == CNT_W'(PAD_W - 1)) ||
                    (col == 0) || (col == CNT_W'(PAD_W - 1));
    assign at_last = (row == CNT_W'(PAD_W - 1)) && (col == CNT_W'(PAD_W - 1));

    // Border positions read nothing from the image.
    assign iaddr = at_pad ? '0 : ADDR_W'((row - 1) * IMG_W + (col - 1));

    // Raster scan over the padded image, one position per cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            row <= '0;
            col <= '0;
        end else if (fetch_start) begin
            running <= 1'b1;
            row <= '0;
            col <= '0;
        end else if (running) begin
            if (col == CNT_W'(PAD_W - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
            if (at_last)
                running <= 1'b0;
        end
    end

    // Newest sample enters at the top end.
    always_ff @(posedge clk) begin
        if (running) begin
            for (int i = 0; i < LB_LEN - 1; i++)
                line_buf[i] <= line_buf[i + 1];
            line_buf[LB_LEN-1] <= at_pad ? pixel_t'(0) : idata;
        end
    end

    // Oldest entry is the top-left tap.
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++)
                window[3*r + c] = line_buf[r*PAD_W + c];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
            last_q <= 1'b0;
            done <= 1'b0;
        end else begin
            win_valid <= running && (row >= 2) && (col >= 2);
            last_q <= running && at_last;
            done <= last_q;   // Lines up with the last result from the MAC.
        end
    end

    always_ff @(posedge clk) begin
        win_index <= ADDR_W'((row - 2) * IMG_W + (col - 2));   // Window centre, unpadded.
    end

endmodule

/* src/cnn_ctrl_pkg.sv */
package cnn_ctrl_pkg;

    // Top-level layer FSM.
    typedef enum logic [2:0] {
        IDLE,
        CONV_K0,
        CONV_K1,
        POOL_K0,
        POOL_K1
    } layer_state_t;

    // Memory select, driven on csel.
    typedef enum logic [2:0] {
        MEM_NONE  = 3'd0,
        MEM_L0_K0 = 3'd1,   // Convolution map, kernel 0.
        MEM_L0_K1 = 3'd2,
        MEM_L1_K0 = 3'd3,   // Pooled map, kernel 0.
        MEM_L1_K1 = 3'd4
    } mem_sel_t;

endpackage

/* src/fixed_point_pkg.sv */
package fixed_point_pkg;

    localparam int PIXEL_W = 20;
    localparam int ACC_W = 2 * PIXEL_W;
    localparam int FRAC_BITS = 16;

    // Rounding keeps bits KEEP_MSB..FRAC_BITS of the sum and adds ROUND_BIT.
    localparam int ROUND_BIT = FRAC_BITS - 1;
    localparam int KEEP_MSB = FRAC_BITS + PIXEL_W - 1;

    typedef logic signed [PIXEL_W-1:0] pixel_t;   // Q4.16 pixel and memory word.
    typedef logic signed [ACC_W-1:0] acc_t;       // Product and sum width.

    // 3x3 weights, row-major.
    localparam pixel_t KERNEL0 [0:8] = '{
        20'h0A89E, 20'h092D5, 20'h06D43,
        20'h01004, 20'hF8F71, 20'hF6E54,
        20'hFA6D7, 20'hFC834, 20'hFAC19
    };

    localparam pixel_t KERNEL1 [0:8] = '{
        20'hFDB55, 20'h02992, 20'hFC994,
        20'h050FD, 20'h02F20, 20'h0202D,
        20'h03BD7, 20'hFD369, 20'h05E68
    };

    localparam pixel_t BIAS0 = 20'h01310;
    localparam pixel_t BIAS1 = 20'hF7295;   // Negative bias.

endpackage
